/* hdl/aes192_top.sv */
////////////////////////////////////////////////////////////
// AES-192 encryptor, valid/ready in and out.
// One block at a time, at least 52 cycles per block.
////////////////////////////////////////////////////////////
module aes192_top
(
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    output logic                in_ready,
    input  aes_pkg::aes_block_t in_block,
    input  aes_pkg::aes_key_t   in_key,
    output logic                out_valid,
    input  logic                out_ready,
    output aes_pkg::aes_block_t out_block
);
    logic               start;
    aes_pkg::aes_key_t  key;
    logic               rk_valid;
    logic               rk_ready;
    aes_pkg::aes_word_t rk_word;
    logic               key_req;
    logic               key_gnt;
    logic               core_req;
    logic               core_gnt;
    aes_pkg::aes_word_t key_sub_in;
    aes_pkg::aes_word_t core_sub_in;
    aes_pkg::aes_word_t sub_out;

    cipher_core i_cipher_core
    (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_block  (in_block),
        .in_key    (in_key),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_block (out_block),
        .start     (start),
        .key       (key),
        .rk_valid  (rk_valid),
        .rk_word   (rk_word),
        .rk_ready  (rk_ready),
        .sub_req   (core_req),
        .sub_in    (core_sub_in),
        .sub_gnt   (core_gnt),
        .sub_out   (sub_out)
    );

    key_schedule i_key_schedule
    (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .key      (key),
        .rk_valid (rk_valid),
        .rk_word  (rk_word),
        .rk_ready (rk_ready),
        .sub_req  (key_req),
        .sub_in   (key_sub_in),
        .sub_gnt  (key_gnt),
        .sub_out  (sub_out)
    );

    sbox_arbiter i_sbox_arbiter
    (
        .key_req     (key_req),
        .key_sub_in  (key_sub_in),
        .key_gnt     (key_gnt),
        .core_req    (core_req),
        .core_sub_in (core_sub_in),
        .core_gnt    (core_gnt),
        .sub_out     (sub_out)
    );

endmodule

/* hdl/aes_cfg.svh */
////////////////////////////////////////////////////////////
// AES-192 constants shared by the package and the RTL.
// Only Nk = 6 is supported by the key schedule.
////////////////////////////////////////////////////////////
`ifndef AES_CFG_SVH
`define AES_CFG_SVH

`define AES_NK          6
`define AES_NR          12
`define AES_SCHED_WORDS 52
`define AES_BLOCK_BITS  128
`define AES_KEY_BITS    192
`define AES_GF_POLY     8'h1b

`endif

/* hdl/aes_pkg.sv */
////////////////////////////////////////////////////////////
// Data types for the AES-192 encryptor.
// Byte 3 of a word is row 0 of a state column.
////////////////////////////////////////////////////////////
`include "aes_cfg.svh"

package aes_pkg;

    typedef logic [7:0] aes_byte_t;

    typedef union packed {
        logic [31:0]          w;   // whole word for xor with key words.
        aes_byte_t [3:0]      b;   // byte lanes, b[3] is row 0.
    } aes_word_t;

    typedef logic [`AES_BLOCK_BITS-1:0] aes_block_t;  // column 0 in the top bits.
    typedef logic [`AES_KEY_BITS-1:0]   aes_key_t;    // word 0 in the top bits.

endpackage

/* hdl/cipher_core.sv */
////////////////////////////////////////////////////////////
// Column-serial AES-192 round datapath and handshakes.
// One block in flight; one column per consumed key word.
// The last round skips MixColumns.
////////////////////////////////////////////////////////////
`include "aes_cfg.svh"

module cipher_core
(
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    output logic                in_ready,
    input  aes_pkg::aes_block_t in_block,
    input  aes_pkg::aes_key_t   in_key,
    output logic                out_valid,
    input  logic                out_ready,
    output aes_pkg::aes_block_t out_block,
    output logic                start,
    output aes_pkg::aes_key_t   key,
    input  logic                rk_valid,
    input  aes_pkg::aes_word_t  rk_word,
    output logic                rk_ready,
    output logic                sub_req,
    output aes_pkg::aes_word_t  sub_in,
    input  logic                sub_gnt,
    input  aes_pkg::aes_word_t  sub_out
);
    aes_pkg::aes_block_t st;
    logic [95:0]         nxt;        // columns 0 to 2 of the next state.
    aes_pkg::aes_word_t  st_col [4];
    aes_pkg::aes_word_t  mixed;
    aes_pkg::aes_word_t  col_out;
    logic [3:0]          round;
    logic [1:0]          col;
    logic                busy;
    logic                step;

    function automatic aes_pkg::aes_byte_t xtime(input aes_pkg::aes_byte_t a);
        return {a[6:0], 1'b0} ^ (a[7] ? `AES_GF_POLY : 8'h00);
    endfunction

    assign in_ready  = !busy && !out_valid;
    assign start     = in_valid && in_ready;
    assign key       = in_key;
    assign out_block = st;
    assign sub_req   = busy && (round != 4'd0);
    assign rk_ready  = busy && ((round == 4'd0) || sub_gnt);
    assign step      = rk_valid && rk_ready;

    always_comb
    begin
        for (int k = 0; k < 4; k++)
            st_col[k].w = st[32*(3-k) +: 32];
        // shiftrows, row j comes from column col + j.
        for (int j = 0; j < 4; j++)
            sub_in.b[3-j] = st_col[(int'(col) + j) % 4].b[3-j];
    end

    always_comb
    begin
        for (int j = 0; j < 4; j++)
            mixed.b[3-j] = xtime(sub_out.b[3-j]) ^ xtime(sub_out.b[3-(j+1)%4])
                         ^ sub_out.b[3-(j+1)%4] ^ sub_out.b[3-(j+2)%4]
                         ^ sub_out.b[3-(j+3)%4];
        if (round == 4'd0)
            col_out.w = st_col[col].w ^ rk_word.w;
        else if (round == 4'(`AES_NR))
            col_out.w = sub_out.w ^ rk_word.w;
        else
            col_out.w = mixed.w ^ rk_word.w;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy      <= 1'b0;
            out_valid <= 1'b0;
            round     <= 4'd0;
            col       <= 2'd0;
        end
        else if (start)
        begin
            busy  <= 1'b1;
            round <= 4'd0;
            col   <= 2'd0;
        end
        else if (step)
        begin
            col <= col + 2'd1;
            if (col == 2'd3)
            begin
                round <= round + 4'd1;
                if (round == 4'(`AES_NR))
                begin
                    busy      <= 1'b0;
                    out_valid <= 1'b1;
                end
            end
        end
        else if (out_ready)
            out_valid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (start)
            st <= in_block;
        else if (step)
        begin
            if (col == 2'd3)
                st <= {nxt, col_out.w};  // round done, swap in.
            else
                nxt[32*(2-int'(col)) +: 32] <= col_out.w;
        end
    end

endmodule

/* hdl/key_schedule.sv */
////////////////////////////////////////////////////////////
// AES-192 key expansion, words w0..w51 in order.
// One-word output slot; SubWord steps take the S-box bank
// only while the slot is empty, costing one bubble each.
////////////////////////////////////////////////////////////
`include "aes_cfg.svh"

module key_schedule
(
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  aes_pkg::aes_key_t  key,
    output logic               rk_valid,
    output aes_pkg::aes_word_t rk_word,
    input  logic               rk_ready,
    output logic               sub_req,
    output aes_pkg::aes_word_t sub_in,
    input  logic               sub_gnt,
    input  aes_pkg::aes_word_t sub_out
);
    aes_pkg::aes_word_t win [6];   // win[0] is w[i-6], win[5] is w[i-1].
    aes_pkg::aes_word_t temp;
    aes_pkg::aes_word_t new_word;
    aes_pkg::aes_byte_t rcon;
    logic [5:0]         idx;
    logic [2:0]         phase;       // idx mod 6.
    logic               busy;
    logic               need_sub;
    logic               gen;

    assign need_sub = (phase == 3'd0) && (idx >= 6'(`AES_NK));
    assign sub_req  = busy && need_sub && !rk_valid;
    assign gen      = busy && (!rk_valid || rk_ready) && (!need_sub || sub_gnt);

    // rotword of the newest word.
    assign sub_in.w = {win[5].b[2], win[5].b[1], win[5].b[0], win[5].b[3]};

    always_comb
    begin
        if (need_sub)
            temp.w = sub_out.w ^ {rcon, 24'h000000};
        else
            temp.w = win[5].w;
        // first six words just rotate the key through.
        if (idx < 6'(`AES_NK))
            new_word.w = win[0].w;
        else
            new_word.w = win[0].w ^ temp.w;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy     <= 1'b0;
            rk_valid <= 1'b0;
            idx      <= 6'd0;
            phase    <= 3'd0;
            rcon     <= 8'h01;
        end
        else if (start)
        begin
            busy     <= 1'b1;
            rk_valid <= 1'b0;
            idx      <= 6'd0;
            phase    <= 3'd0;
            rcon     <= 8'h01;
        end
        else if (gen)
        begin
            rk_valid <= 1'b1;
            idx      <= idx + 6'd1;
            phase    <= (phase == 3'(`AES_NK - 1)) ? 3'd0 : phase + 3'd1;
            if (need_sub)
                rcon <= {rcon[6:0], 1'b0} ^ (rcon[7] ? `AES_GF_POLY : 8'h00);
            if (idx == 6'(`AES_SCHED_WORDS - 1))
                busy <= 1'b0;  // last word is in the slot.
        end
        else if (rk_ready)
            rk_valid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            for (int i = 0; i < 6; i++)
                win[i].w <= key[`AES_KEY_BITS-1-32*i -: 32];
        end
        else if (gen)
        begin
            for (int i = 0; i < 5; i++)
                win[i] <= win[i+1];
            win[5]  <= new_word;
            rk_word <= new_word;
        end
    end

endmodule

/* hdl/sbox_arbiter.sv */
////////////////////////////////////////////////////////////
// Four-lane S-box bank shared by key schedule and cipher.
// Key schedule always wins; grants are combinational.
////////////////////////////////////////////////////////////
module sbox_arbiter
(
    input  logic               key_req,
    input  aes_pkg::aes_word_t key_sub_in,
    output logic               key_gnt,
    input  logic               core_req,
    input  aes_pkg::aes_word_t core_sub_in,
    output logic               core_gnt,
    output aes_pkg::aes_word_t sub_out
);
    aes_pkg::aes_word_t lane_in;

    assign key_gnt  = key_req;
    assign core_gnt = core_req && !key_req;
    assign lane_in  = key_req ? key_sub_in : core_sub_in;  // granted word.

    for (genvar i = 0; i < 4; i++)
    begin : g_lane
        sbox_byte i_sbox_byte
        (
            .in  (lane_in.b[i]),
            .out (sub_out.b[i])
        );
    end

endmodule

/* hdl/sbox_byte.sv */
////////////////////////////////////////////////////////////
// Combinational AES S-box for one byte, built from gates.
// Depth is about 16 levels; no table and no clock.
////////////////////////////////////////////////////////////
module sbox_byte
(
    input  aes_pkg::aes_byte_t in,
    output aes_pkg::aes_byte_t out
);
    logic [0:7]  u;   // u[0] is the msb.
    logic [0:7]  s;
    logic [21:1] y;
    logic [67:0] t;
    logic [0:17] z;

    assign u   = in;
    assign out = s;

    always_comb
    begin
        // linear top layer.
        y[14] = u[3] ^ u[5];
        y[13] = u[0] ^ u[6];
        y[9]  = u[0] ^ u[3];
        y[8]  = u[0] ^ u[5];
        t[0]  = u[1] ^ u[2];
        y[1]  = t[0] ^ u[7];
        y[4]  = y[1] ^ u[3];
        y[12] = y[13] ^ y[14];
        y[2]  = y[1] ^ u[0];
        y[5]  = y[1] ^ u[6];
        y[3]  = y[5] ^ y[8];
        t[1]  = u[4] ^ y[12];
        y[15] = t[1] ^ u[5];
        y[20] = t[1] ^ u[1];
        y[6]  = y[15] ^ u[7];
        y[10] = y[15] ^ t[0];
        y[11] = y[20] ^ y[9];
        y[7]  = u[7] ^ y[11];
        y[17] = y[10] ^ y[11];
        y[19] = y[10] ^ y[8];
        y[16] = t[0] ^ y[11];
        y[21] = y[13] ^ y[16];
        y[18] = u[0] ^ y[16];

        // nonlinear middle, inversion in GF(2^4) towers.
        t[2]  = y[12] & y[15];
        t[3]  = y[3] & y[6];
        t[4]  = t[3] ^ t[2];
        t[5]  = y[4] & u[7];
        t[6]  = t[5] ^ t[2];
        t[7]  = y[13] & y[16];
        t[8]  = y[5] & y[1];
        t[9]  = t[8] ^ t[7];
        t[10] = y[2] & y[7];
        t[11] = t[10] ^ t[7];
        t[12] = y[9] & y[11];
        t[13] = y[14] & y[17];
        t[14] = t[13] ^ t[12];
        t[15] = y[8] & y[10];
        t[16] = t[15] ^ t[12];
        t[17] = t[4] ^ t[14];
        t[18] = t[6] ^ t[16];
        t[19] = t[9] ^ t[14];
        t[20] = t[11] ^ t[16];
        t[21] = t[17] ^ y[20];
        t[22] = t[18] ^ y[19];
        t[23] = t[19] ^ y[21];
        t[24] = t[20] ^ y[18];
        t[25] = t[21] ^ t[22];
        t[26] = t[21] & t[23];
        t[27] = t[24] ^ t[26];
        t[28] = t[25] & t[27];
        t[29] = t[28] ^ t[22];
        t[30] = t[23] ^ t[24];
        t[31] = t[22] ^ t[26];
        t[32] = t[31] & t[30];
        t[33] = t[32] ^ t[24];
        t[34] = t[23] ^ t[33];
        t[35] = t[27] ^ t[33];
        t[36] = t[24] & t[35];
        t[37] = t[36] ^ t[34];
        t[38] = t[27] ^ t[36];
        t[39] = t[29] & t[38];
        t[40] = t[25] ^ t[39];
        t[41] = t[40] ^ t[37];
        t[42] = t[29] ^ t[33];
        t[43] = t[29] ^ t[40];
        t[44] = t[33] ^ t[37];
        t[45] = t[42] ^ t[41];
        z[0:8]  = {t[44], t[37], t[33], t[43], t[40], t[29], t[42], t[45], t[41]}
                & {y[15], y[6], u[7], y[16], y[1], y[7], y[11], y[17], y[10]};
        z[9:17] = {t[44], t[37], t[33], t[43], t[40], t[29], t[42], t[45], t[41]}
                & {y[12], y[3], y[4], y[13], y[5], y[2], y[9], y[14], y[8]};

        // linear bottom layer with the affine constant.
        t[46] = z[15] ^ z[16];
        t[47] = z[10] ^ z[11];
        t[48] = z[5] ^ z[13];
        t[49] = z[9] ^ z[10];
        t[50] = z[2] ^ z[12];
        t[51] = z[2] ^ z[5];
        t[52] = z[7] ^ z[8];
        t[53] = z[0] ^ z[3];
        t[54] = z[6] ^ z[7];
        t[55] = z[16] ^ z[17];
        t[56] = z[12] ^ t[48];
        t[57] = t[50] ^ t[53];
        t[58] = z[4] ^ t[46];
        t[59] = z[3] ^ t[54];
        t[60] = t[46] ^ t[57];
        t[61] = z[14] ^ t[57];
        t[62] = t[52] ^ t[58];
        t[63] = t[49] ^ t[58];
        t[64] = z[4] ^ t[59];
        t[65] = t[61] ^ t[62];
        t[66] = z[1] ^ t[63];
        t[67] = t[64] ^ t[65];
        s[0]  = t[59] ^ t[63];
        s[6]  = ~(t[56] ^ t[62]);
        s[7]  = ~(t[48] ^ t[60]);
        s[3]  = t[53] ^ t[66];
        s[4]  = t[51] ^ t[66];
        s[5]  = t[47] ^ t[65];
        s[1]  = ~(t[64] ^ s[3]);
        s[2]  = ~(t[55] ^ t[67]);
    end

endmodule

/* project.f */
+incdir+hdl
hdl/aes_pkg.sv
hdl/sbox_byte.sv
hdl/sbox_arbiter.sv
hdl/key_schedule.sv
hdl/cipher_core.sv
hdl/aes192_top.sv
test/aes192_tb.sv

/* test/aes192_tb.sv */
////////////////////////////////////////////////////////////
// Testbench for the AES-192 encryptor, known-answer vectors.
// out_ready is random back-pressure; checks are assertions.
////////////////////////////////////////////////////////////
`include "aes_cfg.svh"

module aes192_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 400;

    logic                clk = 1'b0;
    logic                reset;
    logic                in_valid;
    logic                in_ready;
    aes_pkg::aes_block_t in_block;
    aes_pkg::aes_key_t   in_key;
    logic                out_valid;
    logic                out_ready;
    aes_pkg::aes_block_t out_block;

    aes_pkg::aes_block_t in_exp;      // expected result of the block being offered.
    aes_pkg::aes_block_t exp_block;   // expected result of the block in flight.
    logic                pending;
    int                  accepted;
    int                  delivered;
    int                  age;         // cycles since acceptance.
    logic [31:0]         rng;

    aes192_top i_aes192_top
    (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_block  (in_block),
        .in_key    (in_key),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_block (out_block)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    // offer one block and wait until it is taken.
    task automatic send_block(input aes_pkg::aes_key_t k, input aes_pkg::aes_block_t pt,
                              input aes_pkg::aes_block_t ct);
        int target;
        int n;
        target   = accepted + 1;
        n        = 0;
        in_valid = 1'b1;
        in_block = pt;
        in_key   = k;
        in_exp   = ct;
        while (accepted != target)
        begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT_CYCLES)
                stop_on_error("timed out waiting for the DUT to accept a block");
        end
        in_valid = 1'b0;
    endtask

    // random back-pressure, mostly low.
    always @(negedge clk)
    begin
        rng       = xorshift32(rng);
        out_ready = (rng[1:0] == 2'b00);
    end

    // reference bookkeeping of the handshakes.
    always @(posedge clk)
    begin
        if (reset)
        begin
            pending   <= 1'b0;
            accepted  <= 0;
            delivered <= 0;
            age       <= 0;
            exp_block <= '0;
        end
        else
        begin
            if (in_valid && in_ready)
            begin
                pending   <= 1'b1;
                exp_block <= in_exp;
                age       <= 0;
                accepted  <= accepted + 1;
            end
            else if (pending)
                age <= age + 1;
            if (out_valid && out_ready)
            begin
                pending   <= 1'b0;
                delivered <= delivered + 1;
            end
        end
    end

    a_reset_state: assert property (@(posedge clk) $fell(reset) |-> in_ready && !out_valid)
        else stop_on_error($sformatf("MISMATCH in_ready/out_valid: got %h/%h, expected 1/0",
                                     $sampled(in_ready), $sampled(out_valid)));

    a_result: assert property (@(posedge clk) disable iff (reset)
                               out_valid && out_ready |-> out_block == exp_block)
        else stop_on_error($sformatf("MISMATCH out_block: got %h, expected %h",
                                     $sampled(out_block), $sampled(exp_block)));

    a_hold: assert property (@(posedge clk) disable iff (reset)
                             out_valid && !out_ready |=> out_valid && $stable(out_block))
        else stop_on_error("out_valid or out_block changed while out_ready was low");

    a_busy: assert property (@(posedge clk) disable iff (reset) pending |-> !in_ready)
        else stop_on_error("in_ready went high before the result was transferred");

    a_one_out: assert property (@(posedge clk) disable iff (reset) out_valid |-> pending)
        else stop_on_error("out_valid was raised with no accepted block outstanding");

    a_latency: assert property (@(posedge clk) disable iff (reset)
                                out_valid |-> age >= `AES_SCHED_WORDS)
        else stop_on_error($sformatf("result came %0d cycles after acceptance, too early",
                                     $sampled(age)));

    initial
    begin
        int n;
        rng       = 32'd22;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_block  = '0;
        in_key    = '0;
        in_exp    = '0;
        out_ready = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);  // idle check of the reset state.

        // fips-197 c.2, then sp 800-38a ecb, then c.2 again.
        send_block(192'h000102030405060708090a0b0c0d0e0f1011121314151617,
                   128'h00112233445566778899aabbccddeeff,
                   128'hdda97ca4864cdfe06eaf70a0ec0d7191);
        send_block(192'h8e73b0f7da0e6452c810f32b809079e562f8ead2522c6b7b,
                   128'h6bc1bee22e409f96e93d7e117393172a,
                   128'hbd334f1d6e45f25ff712a214571fa5cc);
        send_block(192'h000102030405060708090a0b0c0d0e0f1011121314151617,
                   128'h00112233445566778899aabbccddeeff,
                   128'hdda97ca4864cdfe06eaf70a0ec0d7191);

        n = 0;
        while (delivered != 3)
        begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT_CYCLES)
                stop_on_error("timed out waiting for the last result");
        end
        repeat (4) @(negedge clk);
        $display(">>> PASS");
        $finish;
    end

endmodule
